// ==== rtl/axi_wr_pkg.sv ====
package axi_wr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // AXI4 protocol limits
  ////////////////////////////////////////////////////////////////////////////

  // Longest INCR burst in beats
  localparam int max_burst_len = 256;

  // A burst never crosses a 4 KB boundary
  localparam int max_burst_bytes = 4096;

  ////////////////////////////////////////////////////////////////////////////
  // Shared widths and types
  ////////////////////////////////////////////////////////////////////////////

  // First beats seen on W but not yet matched by an AW
  localparam int w_to_aw_width = 8;

  // AWLEN field, beats minus one
  typedef logic [7:0] axi_len_t;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Smaller of two integers, for elaboration-time sizing
  function automatic int min_int(input int a, input int b);
    return (a < b) ? a : b;
  endfunction

endpackage

// ==== rtl/xfer_counter.sv ====
`timescale 1ns/1ps

module xfer_counter #(
  parameter int width = 8,
  parameter logic [width-1:0] init = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [width-1:0] load_value,
  output logic [width-1:0] count,
  output logic             is_zero
);

  // Load wins over counting
  // Incr and decr together leave the count alone
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= init;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      // Wraps below zero, the beat counter relies on this
      count <= count - 1'b1;
    end
  end

  // Zero flag straight off the count register
  assign is_zero = (count == '0);

endmodule

// ==== rtl/cmd_capture.sv ====
`timescale 1ns/1ps

module cmd_capture #(
  parameter int addr_width      = 32,
  parameter int data_width      = 32,
  parameter int xfer_size_width = 20,
  localparam int bytes_per_beat  = data_width / 8,
  localparam int beats_per_burst = axi_wr_pkg::min_int(
                                     axi_wr_pkg::max_burst_bytes / bytes_per_beat,
                                     axi_wr_pkg::max_burst_len),
  localparam int burst_cnt_width = xfer_size_width - $clog2(bytes_per_beat)
                                   - $clog2(beats_per_burst)
) (
  input  logic                       aclk,
  input  logic                       ctrl_start,
  input  logic [addr_width-1:0]      ctrl_addr_offset,
  input  logic [xfer_size_width-1:0] ctrl_xfer_size,
  output logic                       start,
  output logic [addr_width-1:0]      addr_base,
  output logic [burst_cnt_width-1:0] num_bursts,
  output axi_wr_pkg::axi_len_t       final_len,
  output logic [bytes_per_beat-1:0]  final_strb
);

  import axi_wr_pkg::*;

  localparam int log_bytes       = $clog2(bytes_per_beat);
  localparam int log_burst       = $clog2(beats_per_burst);
  localparam int total_len_width = xfer_size_width - log_bytes;

  // Low address bits inside one burst window
  localparam logic [addr_width-1:0] window_mask =
    addr_width'(bytes_per_beat * beats_per_burst - 1);

  // Two-stage start so the derived values settle first
  logic ctrl_start_d1 = 1'b0;
  logic start_r       = 1'b0;

  // Whole transfer in beats, minus one
  logic [total_len_width-1:0] total_len;
  // Index of the last valid byte in the final beat
  logic [log_bytes-1:0]       last_byte;

  always_ff @(posedge aclk) begin
    ctrl_start_d1 <= ctrl_start;
    start_r       <= ctrl_start_d1;
  end

  assign start = start_r;

  // Command capture on the strobe
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Round a partial beat up, else drop one for the AXI encoding
      if (ctrl_xfer_size[log_bytes-1:0] != '0) begin
        total_len <= ctrl_xfer_size[xfer_size_width-1:log_bytes];
      end else begin
        total_len <= ctrl_xfer_size[xfer_size_width-1:log_bytes] - 1'b1;
      end
      // Snap the start down to a burst boundary
      addr_base <= ctrl_addr_offset & ~window_mask;
      // Remainder of zero wraps to all ones, i.e. a full final beat
      last_byte <= ctrl_xfer_size[log_bytes-1:0] - 1'b1;
    end
  end

  // Derived burst shape, one cycle after capture
  always_ff @(posedge aclk) begin
    num_bursts <= total_len[total_len_width-1:log_burst];
    final_len  <= axi_len_t'(total_len[log_burst-1:0]);
    for (int i = 0; i < bytes_per_beat; i++) begin
      final_strb[i] <= (i <= last_byte);
    end
  end

endmodule

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
  parameter int width = 32,
  parameter int depth = 32
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             push,
  input  logic [width-1:0] push_data,
  input  logic             pop,
  output logic             full,
  output logic             pop_valid,
  output logic [width-1:0] pop_data
);

  localparam int ptr_width = $clog2(depth);
  localparam int cnt_width = $clog2(depth + 1);

  // Storage, no reset needed
  logic [width-1:0]     mem [depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;
  logic [cnt_width-1:0] count_next;
  logic                 do_push;
  logic                 do_pop;

  // Overflow and underflow guards
  assign do_push = push && !full;
  assign do_pop  = pop && pop_valid;

  always_comb begin
    count_next = count;
    if (do_push && !do_pop) begin
      count_next = count + 1'b1;
    end else if (do_pop && !do_push) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Full held high through reset, so the stream side stays stalled
  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_next;
      full  <= (count_next == cnt_width'(depth));
    end
  end

  // Read-ahead: head word shows the cycle after its push
  assign pop_valid = (count != '0);
  assign pop_data  = mem[rd_ptr];

endmodule

// ==== rtl/wdata_channel.sv ====
`timescale 1ns/1ps

module wdata_channel #(
  parameter int data_width      = 32,
  parameter int xfer_size_width = 20,
  localparam int bytes_per_beat  = data_width / 8,
  localparam int beats_per_burst = axi_wr_pkg::min_int(
                                     axi_wr_pkg::max_burst_bytes / bytes_per_beat,
                                     axi_wr_pkg::max_burst_len),
  localparam int burst_cnt_width = xfer_size_width - $clog2(bytes_per_beat)
                                   - $clog2(beats_per_burst)
) (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       start,
  input  logic [burst_cnt_width-1:0] num_bursts,
  input  axi_wr_pkg::axi_len_t       final_len,
  input  logic [bytes_per_beat-1:0]  final_strb,
  input  logic                       fifo_valid,
  input  logic [data_width-1:0]      fifo_data,
  input  logic                       wready,
  output logic                       fifo_pop,
  output logic                       wvalid,
  output logic [data_width-1:0]      wdata,
  output logic [bytes_per_beat-1:0]  wstrb,
  output logic                       wlast,
  output logic                       first_beat
);

  import axi_wr_pkg::*;

  logic                       running;
  logic                       wxfer;
  logic                       final_burst;
  logic                       next_last;
  logic                       load_beats;
  logic [burst_cnt_width-1:0] bursts_to_go;
  // Next valid beat opens a burst
  logic                       wfirst;
  // First beat of this burst already reported
  logic                       first_seen;

  ////////////////////////////////////////////////////////////////////////////
  // W gating
  ////////////////////////////////////////////////////////////////////////////

  // No W traffic until the transfer size is known
  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (start) begin
      running <= 1'b1;
    end else if (wxfer && wlast && final_burst) begin
      running <= 1'b0;
    end
  end

  assign wvalid   = fifo_valid & running;
  assign fifo_pop = wready & running;
  assign wdata    = fifo_data;
  assign wxfer    = wvalid & wready;

  // Trim bytes only on the very last beat
  assign wstrb = (wlast && final_burst) ? final_strb : '1;

  ////////////////////////////////////////////////////////////////////////////
  // Beat and burst counting
  ////////////////////////////////////////////////////////////////////////////

  assign next_last  = (bursts_to_go == burst_cnt_width'(1));
  // Short final burst, either alone or after the full ones
  assign load_beats = (start && num_bursts == '0) || (wxfer && wlast && next_last);

  // Sits at the full length and wraps back to it after each wlast
  xfer_counter #(.width($bits(axi_len_t)), .init('1)) beat_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load_beats),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (final_len),
    .count      (),
    .is_zero    (wlast)
  );

  xfer_counter #(.width(burst_cnt_width), .init('0)) burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (wxfer & wlast),
    .load_value (num_bursts),
    .count      (bursts_to_go),
    .is_zero    (final_burst)
  );

  ////////////////////////////////////////////////////////////////////////////
  // First-beat pulse to the address side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst     <= 1'b1;
      first_seen <= 1'b0;
      first_beat <= 1'b0;
    end else begin
      if (wxfer) begin
        wfirst <= wlast;
      end
      // One pulse per burst even while the first beat stalls
      first_beat <= wvalid & wfirst & ~first_seen;
      if (wxfer) begin
        first_seen <= 1'b0;
      end else if (wvalid && wfirst) begin
        first_seen <= 1'b1;
      end
    end
  end

endmodule

// ==== rtl/addr_resp_channel.sv ====
`timescale 1ns/1ps

module addr_resp_channel #(
  parameter int addr_width      = 32,
  parameter int data_width      = 32,
  parameter int xfer_size_width = 20,
  parameter int max_outstanding = 8,
  localparam int bytes_per_beat  = data_width / 8,
  localparam int beats_per_burst = axi_wr_pkg::min_int(
                                     axi_wr_pkg::max_burst_bytes / bytes_per_beat,
                                     axi_wr_pkg::max_burst_len),
  localparam int burst_cnt_width = xfer_size_width - $clog2(bytes_per_beat)
                                   - $clog2(beats_per_burst)
) (
  input  logic                       aclk,
  input  logic                       areset,
  input  logic                       start,
  input  logic [addr_width-1:0]      addr_base,
  input  logic [burst_cnt_width-1:0] num_bursts,
  input  axi_wr_pkg::axi_len_t       final_len,
  input  logic                       first_beat,
  input  logic                       awready,
  input  logic                       bvalid,
  output logic                       awvalid,
  output logic [addr_width-1:0]      awaddr,
  output axi_wr_pkg::axi_len_t       awlen,
  output logic                       bready,
  output logic                       done
);

  import axi_wr_pkg::*;

  localparam int vac_width = $clog2(max_outstanding + 1);
  localparam logic [addr_width-1:0] window_bytes =
    addr_width'(bytes_per_beat * beats_per_burst);
  localparam axi_len_t full_len = axi_len_t'(beats_per_burst - 1);

  logic                       awxfer;
  logic                       bxfer;
  logic                       idle_aw;
  logic                       aw_final;
  logic                       b_final;
  logic                       stall_aw;

  ////////////////////////////////////////////////////////////////////////////
  // AW channel
  ////////////////////////////////////////////////////////////////////////////

  assign awxfer = awvalid & awready;

  // Only issue once data for the burst is already on W
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid <= 1'b0;
    end else if (!idle_aw && !awvalid && !stall_aw) begin
      awvalid <= 1'b1;
    end else if (awready) begin
      awvalid <= 1'b0;
    end
  end

  // Steps one burst window per accepted AW
  always_ff @(posedge aclk) begin
    if (start) begin
      awaddr <= addr_base;
    end else if (awxfer) begin
      awaddr <= awaddr + window_bytes;
    end
  end

  assign awlen = aw_final ? final_len : full_len;

  // First beats still waiting for their AW
  xfer_counter #(.width(w_to_aw_width), .init('0)) pending_cnt (
    .aclk(aclk), .areset(areset), .load(1'b0), .incr(first_beat), .decr(awxfer),
    .load_value('0), .count(), .is_zero(idle_aw)
  );

  xfer_counter #(.width(burst_cnt_width), .init('0)) aw_cnt (
    .aclk(aclk), .areset(areset), .load(start), .incr(1'b0), .decr(awxfer),
    .load_value(num_bursts), .count(), .is_zero(aw_final)
  );

  ////////////////////////////////////////////////////////////////////////////
  // B channel and outstanding limit
  ////////////////////////////////////////////////////////////////////////////

  assign bready = 1'b1;
  assign bxfer  = bvalid;

  xfer_counter #(.width(burst_cnt_width), .init('0)) b_cnt (
    .aclk(aclk), .areset(areset), .load(start), .incr(1'b0), .decr(bxfer),
    .load_value(num_bursts), .count(), .is_zero(b_final)
  );

  // Free slots: an AW takes one, a B gives it back
  xfer_counter #(.width(vac_width), .init(vac_width'(max_outstanding))) vacancy_cnt (
    .aclk(aclk), .areset(areset), .load(1'b0), .incr(bxfer), .decr(awxfer),
    .load_value('0), .count(), .is_zero(stall_aw)
  );

  // One cycle after the last response
  always_ff @(posedge aclk) begin
    if (areset) begin
      done <= 1'b0;
    end else begin
      done <= bxfer & b_final;
    end
  end

endmodule

// ==== rtl/axi_write_master.sv ====
`timescale 1ns/1ps

module axi_write_master #(
  parameter int addr_width      = 32,
  parameter int data_width      = 32,
  parameter int xfer_size_width = 20,
  parameter int max_outstanding = 8,
  parameter int fifo_depth      = 32,
  localparam int bytes_per_beat  = data_width / 8,
  localparam int beats_per_burst = axi_wr_pkg::min_int(
                                     axi_wr_pkg::max_burst_bytes / bytes_per_beat,
                                     axi_wr_pkg::max_burst_len),
  localparam int burst_cnt_width = xfer_size_width - $clog2(bytes_per_beat)
                                   - $clog2(beats_per_burst)
) (
  input  logic                       aclk,
  input  logic                       areset,
  // Control
  input  logic                       ctrl_start,
  input  logic [addr_width-1:0]      ctrl_addr_offset,
  input  logic [xfer_size_width-1:0] ctrl_xfer_size,
  output logic                       ctrl_done,
  // Stream in
  input  logic                       s_axis_tvalid,
  input  logic [data_width-1:0]      s_axis_tdata,
  output logic                       s_axis_tready,
  // AXI4 write address
  output logic                       m_axi_awvalid,
  output logic [addr_width-1:0]      m_axi_awaddr,
  output axi_wr_pkg::axi_len_t       m_axi_awlen,
  input  logic                       m_axi_awready,
  // AXI4 write data
  output logic                       m_axi_wvalid,
  output logic [data_width-1:0]      m_axi_wdata,
  output logic [bytes_per_beat-1:0]  m_axi_wstrb,
  output logic                       m_axi_wlast,
  input  logic                       m_axi_wready,
  // AXI4 write response
  input  logic                       m_axi_bvalid,
  output logic                       m_axi_bready
);

  import axi_wr_pkg::*;

  logic                       start;
  logic [addr_width-1:0]      addr_base;
  logic [burst_cnt_width-1:0] num_bursts;
  axi_len_t                   final_len;
  logic [bytes_per_beat-1:0]  final_strb;
  logic                       fifo_full;
  logic                       fifo_valid;
  logic [data_width-1:0]      fifo_data;
  logic                       fifo_pop;
  logic                       first_beat;

  ////////////////////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////////////////////

  cmd_capture #(
    .addr_width(addr_width), .data_width(data_width), .xfer_size_width(xfer_size_width)
  ) cmd0 (
    .aclk(aclk), .ctrl_start(ctrl_start), .ctrl_addr_offset(ctrl_addr_offset),
    .ctrl_xfer_size(ctrl_xfer_size), .start(start), .addr_base(addr_base),
    .num_bursts(num_bursts), .final_len(final_len), .final_strb(final_strb)
  );

  // Stream accepted whenever the buffer has room
  assign s_axis_tready = ~fifo_full;

  stream_fifo #(.width(data_width), .depth(fifo_depth)) fifo0 (
    .aclk(aclk), .areset(areset), .push(s_axis_tvalid & ~fifo_full),
    .push_data(s_axis_tdata), .pop(fifo_pop), .full(fifo_full),
    .pop_valid(fifo_valid), .pop_data(fifo_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // W channel
  ////////////////////////////////////////////////////////////////////////////

  wdata_channel #(.data_width(data_width), .xfer_size_width(xfer_size_width)) wch0 (
    .aclk(aclk), .areset(areset), .start(start), .num_bursts(num_bursts),
    .final_len(final_len), .final_strb(final_strb), .fifo_valid(fifo_valid),
    .fifo_data(fifo_data), .wready(m_axi_wready), .fifo_pop(fifo_pop),
    .wvalid(m_axi_wvalid), .wdata(m_axi_wdata), .wstrb(m_axi_wstrb),
    .wlast(m_axi_wlast), .first_beat(first_beat)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output side, AW and B
  ////////////////////////////////////////////////////////////////////////////

  addr_resp_channel #(
    .addr_width(addr_width), .data_width(data_width),
    .xfer_size_width(xfer_size_width), .max_outstanding(max_outstanding)
  ) arc0 (
    .aclk(aclk), .areset(areset), .start(start), .addr_base(addr_base),
    .num_bursts(num_bursts), .final_len(final_len), .first_beat(first_beat),
    .awready(m_axi_awready), .bvalid(m_axi_bvalid), .awvalid(m_axi_awvalid),
    .awaddr(m_axi_awaddr), .awlen(m_axi_awlen), .bready(m_axi_bready),
    .done(ctrl_done)
  );

endmodule

// ==== sim/tb_axi_write_master.sv ====
`timescale 1ns/1ps

module tb_axi_write_master;

  import axi_wr_pkg::*;

  localparam int addr_width      = 32;
  localparam int data_width      = 32;
  localparam int xfer_size_width = 20;
  localparam int max_outstanding = 8;
  localparam int fifo_depth      = 32;
  localparam int strb_width      = data_width / 8;
  localparam int burst_beats     = 256;
  localparam int window_bytes    = 1024;

  // W ready patterns
  localparam int mode_ready  = 0;
  localparam int mode_random = 1;
  localparam int mode_hold   = 2;

  logic                       aclk;
  logic                       areset;
  logic                       ctrl_start;
  logic [addr_width-1:0]      ctrl_addr_offset;
  logic [xfer_size_width-1:0] ctrl_xfer_size;
  logic                       ctrl_done;
  logic                       s_axis_tvalid;
  logic [data_width-1:0]      s_axis_tdata;
  logic                       s_axis_tready;
  logic                       m_axi_awvalid;
  logic [addr_width-1:0]      m_axi_awaddr;
  axi_len_t                   m_axi_awlen;
  logic                       m_axi_awready;
  logic                       m_axi_wvalid;
  logic [data_width-1:0]      m_axi_wdata;
  logic [strb_width-1:0]      m_axi_wstrb;
  logic                       m_axi_wlast;
  logic                       m_axi_wready;
  logic                       m_axi_bvalid;
  logic                       m_axi_bready;

  string                 test_name;
  logic [31:0]           lcg_state;
  logic [data_width-1:0] exp_data [4096];
  int                    exp_beats;
  int                    exp_bursts;
  axi_len_t              exp_final_len;
  logic [strb_width-1:0] exp_strb;
  logic [addr_width-1:0] exp_base;
  int                    stream_idx;
  int                    stream_total;
  int                    w_count;
  int                    wlast_count;
  int                    aw_count;
  int                    b_count;
  int                    b_issued;
  int                    b_wait;
  int                    done_count;
  int                    peak_outstanding;
  int                    w_mode;
  logic                  aw_random;
  logic                  b_random;
  logic                  b_hold;
  logic                  last_b_seen;
  logic                  aw_hold;
  logic [addr_width-1:0] aw_hold_addr;
  axi_len_t              aw_hold_len;
  logic [addr_width-1:0] aw_addr_q [$];
  axi_len_t              aw_len_q [$];

  always #5 aclk = ~aclk;

  axi_write_master #(
    .addr_width(addr_width), .data_width(data_width), .xfer_size_width(xfer_size_width),
    .max_outstanding(max_outstanding), .fifo_depth(fifo_depth)
  ) dut0 (
    .aclk(aclk), .areset(areset), .ctrl_start(ctrl_start),
    .ctrl_addr_offset(ctrl_addr_offset), .ctrl_xfer_size(ctrl_xfer_size),
    .ctrl_done(ctrl_done), .s_axis_tvalid(s_axis_tvalid), .s_axis_tdata(s_axis_tdata),
    .s_axis_tready(s_axis_tready), .m_axi_awvalid(m_axi_awvalid),
    .m_axi_awaddr(m_axi_awaddr), .m_axi_awlen(m_axi_awlen), .m_axi_awready(m_axi_awready),
    .m_axi_wvalid(m_axi_wvalid), .m_axi_wdata(m_axi_wdata), .m_axi_wstrb(m_axi_wstrb),
    .m_axi_wlast(m_axi_wlast), .m_axi_wready(m_axi_wready), .m_axi_bvalid(m_axi_bvalid),
    .m_axi_bready(m_axi_bready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random source and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_addr(input string what, input logic [addr_width-1:0] exp,
                            input logic [addr_width-1:0] act);
    if (act !== exp) begin
      fail_now($sformatf("Error in %s: %s expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_len(input string what, input axi_len_t exp, input axi_len_t act);
    if (act !== exp) begin
      fail_now($sformatf("Error in %s: %s expected %0d, actual %0d", test_name, what, exp, act));
    end
  endtask

  task automatic check_data(input string what, input logic [data_width-1:0] exp,
                            input logic [data_width-1:0] act);
    if (act !== exp) begin
      fail_now($sformatf("Error in %s: %s expected %h, actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_strb(input string what, input logic [strb_width-1:0] exp,
                            input logic [strb_width-1:0] act);
    if (act !== exp) begin
      fail_now($sformatf("Error in %s: %s expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("Error in %s: %s expected %b, actual %b", test_name, what, exp, act));
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
      fail_now($sformatf("Error in %s: %s expected %0d, actual %0d", test_name, what, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Slave model and stream driver
  ////////////////////////////////////////////////////////////////////////////

  // Inputs change on the falling edge only
  always @(negedge aclk) begin : drive
    logic [31:0] r;
    int          ready_bursts;
    r = next_random();
    m_axi_awready = aw_random ? r[7] : 1'b1;
    case (w_mode)
      mode_random: m_axi_wready = r[13] | r[14];
      mode_hold:   m_axi_wready = 1'b0;
      default:     m_axi_wready = 1'b1;
    endcase
    s_axis_tvalid = (stream_idx < stream_total);
    s_axis_tdata  = exp_data[stream_idx % 4096];
    // A burst may respond once both its AW and its wlast are in
    ready_bursts = (aw_count < wlast_count) ? aw_count : wlast_count;
    m_axi_bvalid = 1'b0;
    // Held responses let the AW side run into its outstanding limit
    if (b_issued < ready_bursts && !(b_hold && w_count < exp_beats)) begin
      if (b_wait == 0) begin
        m_axi_bvalid = 1'b1;
        b_issued++;
        b_wait = b_random ? int'(r[19:16]) : 0;
      end else begin
        b_wait--;
      end
    end
  end

  always @(posedge aclk) begin : monitor
    int k;
    int len;
    if (!areset) begin
      // Stalled AW stays put
      if (aw_hold) begin
        check_bit("awvalid held", 1'b1, m_axi_awvalid);
        check_addr("held awaddr", aw_hold_addr, m_axi_awaddr);
        check_len("held awlen", aw_hold_len, m_axi_awlen);
      end
      aw_hold      = m_axi_awvalid && !m_axi_awready;
      aw_hold_addr = m_axi_awaddr;
      aw_hold_len  = m_axi_awlen;
      if (m_axi_awvalid && m_axi_awready) begin
        aw_addr_q.push_back(m_axi_awaddr);
        aw_len_q.push_back(m_axi_awlen);
        aw_count++;
      end
      if (m_axi_wvalid && m_axi_wready) begin
        if (w_count >= exp_beats) begin
          fail_now($sformatf("W beat beyond the end of the transfer in %s", test_name));
        end else begin
          // Full bursts first, the remainder last
          k   = w_count % burst_beats;
          len = (w_count / burst_beats < exp_bursts - 1) ? burst_beats : exp_final_len + 1;
          check_data("wdata", exp_data[w_count], m_axi_wdata);
          check_bit("wlast", k == len - 1, m_axi_wlast);
          check_strb("wstrb", (w_count == exp_beats - 1) ? exp_strb : '1, m_axi_wstrb);
          if (m_axi_wlast) begin
            wlast_count++;
          end
          w_count++;
        end
      end
      if (s_axis_tvalid && s_axis_tready) begin
        stream_idx++;
      end
      // Done exactly one cycle after the final B
      check_bit("ctrl_done", last_b_seen, ctrl_done);
      if (ctrl_done) begin
        done_count++;
      end
      last_b_seen = 1'b0;
      if (m_axi_bvalid) begin
        check_bit("bready", 1'b1, m_axi_bready);
        b_count++;
        last_b_seen = (b_count == exp_bursts);
      end
      if (aw_count - b_count > max_outstanding) begin
        fail_now($sformatf("Too many outstanding bursts in %s", test_name));
      end
      if (aw_count - b_count > peak_outstanding) begin
        peak_outstanding = aw_count - b_count;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Transfer helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_tready(input logic level, input int limit);
    int n;
    n = 0;
    while (s_axis_tready !== level) begin
      @(negedge aclk);
      n++;
      if (n > limit) begin
        fail_now($sformatf("Timeout in %s: tready never went %b", test_name, level));
      end
    end
  endtask

  // Expected shape from the byte count and offset
  task automatic start_transfer(input string name, input logic [addr_width-1:0] offset,
                                input int bytes);
    int rem;
    int i;
    test_name     = name;
    exp_beats     = (bytes + strb_width - 1) / strb_width;
    exp_bursts    = (exp_beats - 1) / burst_beats + 1;
    exp_final_len = axi_len_t'((exp_beats - 1) % burst_beats);
    rem           = bytes % strb_width;
    exp_strb      = (rem == 0) ? '1 : strb_width'((1 << rem) - 1);
    exp_base      = offset & ~addr_width'(window_bytes - 1);
    for (i = 0; i < exp_beats; i++) begin
      exp_data[i] = next_random();
    end
    stream_idx       = 0;
    w_count          = 0;
    wlast_count      = 0;
    aw_count         = 0;
    b_count          = 0;
    b_issued         = 0;
    b_wait           = 0;
    done_count       = 0;
    peak_outstanding = 0;
    aw_addr_q.delete();
    aw_len_q.delete();
    stream_total     = exp_beats;
    ctrl_addr_offset = offset;
    ctrl_xfer_size   = xfer_size_width'(bytes);
    ctrl_start       = 1'b1;
    @(negedge aclk);
    ctrl_start = 1'b0;
  endtask

  task automatic finish_transfer(input int limit);
    int n;
    int i;
    n = 0;
    while (done_count == 0) begin
      @(negedge aclk);
      n++;
      if (n > limit) begin
        fail_now($sformatf("Timeout in %s: no ctrl_done after %0d cycles", test_name, limit));
      end
    end
    // Quiet window to catch a second pulse
    repeat (8) @(negedge aclk);
    check_count("done pulses", 1, done_count);
    check_count("W beats", exp_beats, w_count);
    check_count("AW bursts", exp_bursts, aw_count);
    check_count("B responses", exp_bursts, b_count);
    for (i = 0; i < exp_bursts; i++) begin
      check_addr($sformatf("awaddr %0d", i), exp_base + addr_width'(i * window_bytes),
                 aw_addr_q[i]);
      check_len($sformatf("awlen %0d", i),
                (i < exp_bursts - 1) ? axi_len_t'(burst_beats - 1) : exp_final_len,
                aw_len_q[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_and_short_transfer();
    test_name = "reset";
    @(negedge aclk);
    check_bit("tready during reset", 1'b0, s_axis_tready);
    @(negedge aclk);
    areset = 1'b0;
    wait_tready(1'b1, 10);
    check_bit("awvalid after reset", 1'b0, m_axi_awvalid);
    check_bit("wvalid after reset", 1'b0, m_axi_wvalid);
    check_bit("ctrl_done after reset", 1'b0, ctrl_done);
    // Three beats, last one two bytes wide
    start_transfer("single short transfer", 32'h0000_3000, 10);
    finish_transfer(200);
  endtask

  task automatic multi_burst_transfer();
    start_transfer("multi burst transfer", 32'h0001_0000, 2500);
    finish_transfer(5000);
  endtask

  task automatic address_masking();
    start_transfer("address masking", 32'h0000_1234, 64);
    finish_transfer(500);
    check_addr("masked start address", 32'h0000_1000, aw_addr_q[0]);
  endtask

  task automatic random_backpressure();
    aw_random = 1'b1;
    b_random  = 1'b1;
    b_hold    = 1'b1;
    w_mode    = mode_random;
    // Ten bursts, more than the outstanding limit
    start_transfer("random back-pressure", 32'h0004_5678, 10002);
    finish_transfer(30000);
    check_count("peak outstanding bursts", max_outstanding, peak_outstanding);
    aw_random = 1'b0;
    b_random  = 1'b0;
    b_hold    = 1'b0;
    w_mode    = mode_ready;
  endtask

  task automatic stream_backpressure();
    w_mode = mode_hold;
    start_transfer("stream back-pressure", 32'h0008_0000, 400);
    wait_tready(1'b0, 200);
    // Buffer takes exactly its depth then stalls the stream
    check_count("stream beats before tready fell", fifo_depth, stream_idx);
    w_mode = mode_ready;
    finish_transfer(2000);
  endtask

  initial begin
    aclk             = 1'b0;
    areset           = 1'b1;
    ctrl_start       = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size   = '0;
    s_axis_tvalid    = 1'b0;
    s_axis_tdata     = '0;
    m_axi_awready    = 1'b0;
    m_axi_wready     = 1'b0;
    m_axi_bvalid     = 1'b0;
    lcg_state        = 32'd80716;
    w_mode           = mode_ready;
    aw_random        = 1'b0;
    b_random         = 1'b0;
    b_hold           = 1'b0;
    last_b_seen      = 1'b0;
    aw_hold          = 1'b0;
    stream_total     = 0;
    exp_beats        = 0;
    exp_bursts       = 0;
    peak_outstanding = 0;
    reset_and_short_transfer();
    multi_burst_transfer();
    address_masking();
    random_backpressure();
    stream_backpressure();
    $display("test passed");
    $finish;
  end

endmodule

// ==== sim.f ====
rtl/axi_wr_pkg.sv
rtl/xfer_counter.sv
rtl/cmd_capture.sv
rtl/stream_fifo.sv
rtl/wdata_channel.sv
rtl/addr_resp_channel.sv
rtl/axi_write_master.sv
sim/tb_axi_write_master.sv
